// File: common/lab_cfg.svh
`ifndef LAB_CFG_SVH
`define LAB_CFG_SVH

// ----------------------------------------
// Board port widths
// ----------------------------------------
`define LAB_W_KEY          4
`define LAB_W_SW           8
`define LAB_W_LED          8
`define LAB_W_DIGIT        8

// Width of the decoded input word
`define LAB_W_IN           8

// ----------------------------------------
// Timing constants, simulation values
// ----------------------------------------
// Low free counter bits, 20 on the board
`define LAB_TICK_BITS      6
// Slow strobe period in clk cycles
`define LAB_SLOW_PERIOD    16
`define LAB_STROBE_PERIOD  24
// Cycles each digit stays lit
`define LAB_SCAN_PERIOD    4

`endif

// File: common/lab_pkg.sv
`default_nettype none

`include "lab_cfg.svh"

package lab_pkg;

    // ----------------------------------------
    // Select code from key or switch bits 3:1
    // ----------------------------------------
    typedef enum logic [2:0]
    {
        sel_default = 3'd0,
        sel_slow    = 3'd1,
        sel_win_hi  = 3'd2,
        sel_win_mid = 3'd3,
        sel_win_lo  = 3'd4,
        sel_tick    = 3'd5,
        sel_strobe  = 3'd6
    } sel_e;

    // Decoded input, 4 bits
    typedef struct packed
    {
        sel_e sel;
        logic any_active;
    } input_t;

    // All counters of the execute stage, 56 bits
    typedef struct packed
    {
        logic [`LAB_W_LED - 1:0] slow_cnt;
        logic [31:0]             free_cnt;
        logic [`LAB_W_LED - 1:0] tick_cnt;
        logic [`LAB_W_LED - 1:0] strobe_cnt;
    } counters_t;

    typedef logic [`LAB_W_LED - 1:0] led_t;

    // Eight hex nibbles for the display
    typedef logic [`LAB_W_DIGIT * 4 - 1:0] number_t;

endpackage

`default_nettype wire

// File: source/input_decode.sv
`timescale 1ns/1ns
`default_nettype none

`include "lab_cfg.svh"

module input_decode
(
    input  wire                       clk,
    input  wire                       rst_from_key0,
    input  wire  [`LAB_W_KEY - 1:0]   key,
    input  wire  [`LAB_W_SW  - 1:0]   sw,
    output lab_pkg::input_t           inputs
);

    import lab_pkg::*;

    localparam w_in = `LAB_W_IN;

    logic [w_in - 1:0] in_raw;
    logic [w_in - 1:0] in_meta;
    logic [w_in - 1:0] in_sync;

    // ----------------------------------------
    // Source choice
    // ----------------------------------------
    generate
        if (`LAB_W_KEY < w_in && `LAB_W_SW >= w_in)
        begin : use_switches
            assign in_raw = w_in'(sw);
        end
        else
        begin : use_keys
            assign in_raw = w_in'(key);
        end
    endgenerate

    // Two-flop synchronizer
    always_ff @(posedge clk)
    begin
        if (rst_from_key0)
        begin
            in_meta <= '0;
            in_sync <= '0;
        end
        else
        begin
            in_meta <= in_raw;
            in_sync <= in_meta;
        end
    end

    // ----------------------------------------
    // Select decode
    // ----------------------------------------
    always_comb
    begin
        case (in_sync[3:1])
            3'd1:    inputs.sel = sel_slow;
            3'd2:    inputs.sel = sel_win_hi;
            3'd3:    inputs.sel = sel_win_mid;
            3'd4:    inputs.sel = sel_win_lo;
            3'd5:    inputs.sel = sel_tick;
            3'd6:    inputs.sel = sel_strobe;
            // Codes 0 and 7
            default: inputs.sel = sel_default;
        endcase
        inputs.any_active = |in_sync;
    end

endmodule

`default_nettype wire

// File: counters/strobe_gen.sv
`timescale 1ns/1ns
`default_nettype none

module strobe_gen
#(
    parameter int period = 16
)
(
    input  wire  clk,
    input  wire  rst_from_key0,
    output logic strobe
);

    // At least one bit even for period 1
    localparam int w_cnt = (period > 1) ? $clog2(period) : 1;

    logic [w_cnt - 1:0] cnt;

    // Down-counter, strobe on reload
    always_ff @(posedge clk)
    begin
        if (rst_from_key0)
        begin
            cnt    <= w_cnt'(period - 1);
            strobe <= 1'b0;
        end
        else if (cnt == '0)
        begin
            cnt    <= w_cnt'(period - 1);
            strobe <= 1'b1;
        end
        else
        begin
            cnt    <= cnt - 1'b1;
            strobe <= 1'b0;
        end
    end

    // Strobe is a single-cycle pulse
    generate
        if (period > 1)
        begin : g_pulse_check
            a_single_pulse : assert property (
                @(posedge clk) disable iff (rst_from_key0) strobe |=> !strobe);
        end
    endgenerate

endmodule

`default_nettype wire

// File: counters/counter_bank.sv
`timescale 1ns/1ns
`default_nettype none

`include "lab_cfg.svh"

module counter_bank
(
    input  wire                 clk,
    input  wire                 rst_from_key0,
    output lab_pkg::counters_t  counters
);

    import lab_pkg::*;

    logic slow_strobe;
    logic cnt_strobe;
    logic tick_wrap;

    // ----------------------------------------
    // Strobe sources
    // ----------------------------------------
    // Stands in for the board slow clock
    strobe_gen
    #(
        .period (`LAB_SLOW_PERIOD)
    )
    u_slow_strobe
    (
        .clk           (clk),
        .rst_from_key0 (rst_from_key0),
        .strobe        (slow_strobe)
    );

    strobe_gen
    #(
        .period (`LAB_STROBE_PERIOD)
    )
    u_cnt_strobe
    (
        .clk           (clk),
        .rst_from_key0 (rst_from_key0),
        .strobe        (cnt_strobe)
    );

    // Low free counter bits wrapped
    assign tick_wrap = (counters.free_cnt[`LAB_TICK_BITS - 1:0] == '0);

    // ----------------------------------------
    // Counters
    // ----------------------------------------
    always_ff @(posedge clk)
    begin
        if (rst_from_key0)
        begin
            counters <= '0;
        end
        else
        begin
            counters.free_cnt <= counters.free_cnt + 1'b1;
            if (slow_strobe)
                counters.slow_cnt <= counters.slow_cnt + 1'b1;
            if (tick_wrap)
                counters.tick_cnt <= counters.tick_cnt + 1'b1;
            if (cnt_strobe)
                counters.strobe_cnt <= counters.strobe_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: source/result_select.sv
`timescale 1ns/1ns
`default_nettype none

module result_select
(
    input  wire                 clk,
    input  wire                 rst_from_key0,
    input  lab_pkg::input_t     inputs,
    input  lab_pkg::counters_t  counters,
    output lab_pkg::led_t       led,
    output lab_pkg::number_t    number
);

    import lab_pkg::*;

    led_t    picked;
    number_t number_next;

    // ----------------------------------------
    // Counter pick
    // ----------------------------------------
    always_comb
    begin
        case (inputs.sel)
            sel_slow:    picked = counters.slow_cnt;
            sel_win_hi:  picked = counters.free_cnt[31:24];
            sel_win_mid: picked = counters.free_cnt[23:16];
            // Overlaps the middle window
            sel_win_lo:  picked = counters.free_cnt[19:12];
            sel_tick:    picked = counters.tick_cnt;
            sel_strobe:  picked = counters.strobe_cnt;
            default:     picked = counters.free_cnt[31:24];
        endcase
    end

    // Idle inputs show the raw free counter
    assign number_next = inputs.any_active ? number_t'(picked)
                                           : number_t'(counters.free_cnt);

    // Result registers
    always_ff @(posedge clk)
    begin
        if (rst_from_key0)
        begin
            led    <= '0;
            number <= '0;
        end
        else
        begin
            led    <= picked;
            number <= number_next;
        end
    end

endmodule

`default_nettype wire

// File: display/seven_segment_display.sv
`timescale 1ns/1ns
`default_nettype none

`include "lab_cfg.svh"

module seven_segment_display
(
    input  wire                        clk,
    input  wire                        rst_from_key0,
    input  lab_pkg::number_t           number,
    output logic [7:0]                 abcdefgh,
    output logic [`LAB_W_DIGIT - 1:0]  digit
);

    import lab_pkg::*;

    localparam int w_scan = (`LAB_SCAN_PERIOD > 1) ? $clog2(`LAB_SCAN_PERIOD) : 1;
    localparam int w_idx  = $clog2(`LAB_W_DIGIT);

    logic [w_scan - 1:0] scan_cnt;
    logic [w_idx - 1:0]  idx;
    logic [3:0]          nibble;

    // Hex to segments with a in bit 7 and dot off
    function automatic logic [7:0] hex_to_seg(input logic [3:0] hex);
        case (hex)
            4'h0:    hex_to_seg = 8'b1111_1100;
            4'h1:    hex_to_seg = 8'b0110_0000;
            4'h2:    hex_to_seg = 8'b1101_1010;
            4'h3:    hex_to_seg = 8'b1111_0010;
            4'h4:    hex_to_seg = 8'b0110_0110;
            4'h5:    hex_to_seg = 8'b1011_0110;
            4'h6:    hex_to_seg = 8'b1011_1110;
            4'h7:    hex_to_seg = 8'b1110_0000;
            4'h8:    hex_to_seg = 8'b1111_1110;
            4'h9:    hex_to_seg = 8'b1111_0110;
            4'ha:    hex_to_seg = 8'b1110_1110;
            4'hb:    hex_to_seg = 8'b0011_1110;
            4'hc:    hex_to_seg = 8'b1001_1100;
            4'hd:    hex_to_seg = 8'b0111_1010;
            4'he:    hex_to_seg = 8'b1001_1110;
            default: hex_to_seg = 8'b1000_1110;
        endcase
    endfunction

    // ----------------------------------------
    // Digit scan
    // ----------------------------------------
    always_ff @(posedge clk)
    begin
        if (rst_from_key0)
        begin
            scan_cnt <= '0;
            idx      <= '0;
        end
        else if (scan_cnt == w_scan'(`LAB_SCAN_PERIOD - 1))
        begin
            scan_cnt <= '0;
            // Wrap after the last digit
            idx <= (idx == w_idx'(`LAB_W_DIGIT - 1)) ? '0 : idx + 1'b1;
        end
        else
        begin
            scan_cnt <= scan_cnt + 1'b1;
        end
    end

    assign nibble = number[idx * 4 +: 4];

    // Segment and digit registers kept aligned
    always_ff @(posedge clk)
    begin
        if (rst_from_key0)
        begin
            abcdefgh <= hex_to_seg(4'h0);
            digit    <= `LAB_W_DIGIT'(1);
        end
        else
        begin
            abcdefgh <= hex_to_seg(nibble);
            digit    <= `LAB_W_DIGIT'(1) << idx;
        end
    end

    // Each change of digit is one step to the left with wrap
    a_digit_step : assert property (
        @(posedge clk) disable iff (rst_from_key0)
        !$stable(digit) |-> digit == {$past(digit[`LAB_W_DIGIT - 2:0]),
                                      $past(digit[`LAB_W_DIGIT - 1])});

endmodule

`default_nettype wire

// File: source/lab_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "lab_cfg.svh"

module lab_top
(
    input  wire                        clk,
    input  wire                        rst_from_key0,
    input  wire  [`LAB_W_KEY   - 1:0]  key,
    input  wire  [`LAB_W_SW    - 1:0]  sw,
    output logic [`LAB_W_LED   - 1:0]  led,
    output logic [7:0]                 abcdefgh,
    output logic [`LAB_W_DIGIT - 1:0]  digit
);

    import lab_pkg::*;

    input_t    dec_inputs;
    counters_t cnt_values;
    number_t   disp_number;

    // ----------------------------------------
    // Decode stage
    // ----------------------------------------
    input_decode u_input_decode
    (
        .clk           (clk),
        .rst_from_key0 (rst_from_key0),
        .key           (key),
        .sw            (sw),
        .inputs        (dec_inputs)
    );

    // Execute stage
    counter_bank u_counter_bank
    (
        .clk           (clk),
        .rst_from_key0 (rst_from_key0),
        .counters      (cnt_values)
    );

    // ----------------------------------------
    // Result stage
    // ----------------------------------------
    result_select u_result_select
    (
        .clk           (clk),
        .rst_from_key0 (rst_from_key0),
        .inputs        (dec_inputs),
        .counters      (cnt_values),
        .led           (led),
        .number        (disp_number)
    );

    seven_segment_display u_seven_segment_display
    (
        .clk           (clk),
        .rst_from_key0 (rst_from_key0),
        .number        (disp_number),
        .abcdefgh      (abcdefgh),
        .digit         (digit)
    );

endmodule

`default_nettype wire

// File: verification/tb_lab_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "lab_cfg.svh"

module tb_lab_top;

    import lab_pkg::*;

    // ----------------------------------------
    // Test lengths
    // ----------------------------------------
    localparam int n_reset_cycles = 16;
    localparam int n_segments     = 120;
    localparam int max_hold       = 24;
    localparam int tick_hold      = 5 * (1 << `LAB_TICK_BITS);
    localparam int strobe_hold    = 5 * `LAB_STROBE_PERIOD;
    localparam int max_cycles     = n_reset_cycles + n_segments * max_hold
                                    + tick_hold + strobe_hold + 8;
    // Switches win when keys are too narrow
    localparam bit use_sw = (`LAB_W_KEY < `LAB_W_IN) && (`LAB_W_SW >= `LAB_W_IN);

    logic                      clk;
    logic                      rst_from_key0;
    logic [`LAB_W_KEY - 1:0]   key;
    logic [`LAB_W_SW - 1:0]    sw;
    led_t                      led;
    logic [7:0]                abcdefgh;
    logic [`LAB_W_DIGIT - 1:0] digit;

    // Reference model state after each edge
    logic [31:0]               rng_state;
    counters_t                 m_cnt;
    int                        m_run;
    logic [`LAB_W_IN - 1:0]    m_meta;
    logic [`LAB_W_IN - 1:0]    m_sync;
    led_t                      m_led;
    number_t                   m_num;
    logic [7:0]                m_seg;
    logic [`LAB_W_DIGIT - 1:0] m_digit;
    int                        m_scan;
    int                        m_idx;

    lab_top u_lab_top
    (
        .clk           (clk),
        .rst_from_key0 (rst_from_key0),
        .key           (key),
        .sw            (sw),
        .led           (led),
        .abcdefgh      (abcdefgh),
        .digit         (digit)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // Select code sits in bits 3:1
    // Codes 0 and 7 fall back to the top window
    function automatic led_t pick_value(input logic [`LAB_W_IN - 1:0] word, input counters_t c);
        case (word[3:1])
            3'd1:    pick_value = c.slow_cnt;
            3'd2:    pick_value = c.free_cnt[31:24];
            3'd3:    pick_value = c.free_cnt[23:16];
            3'd4:    pick_value = c.free_cnt[19:12];
            3'd5:    pick_value = c.tick_cnt;
            3'd6:    pick_value = c.strobe_cnt;
            default: pick_value = c.free_cnt[31:24];
        endcase
    endfunction

    // Lit segments by letter
    // Segment a is bit 7 and g is bit 1
    function automatic logic [7:0] seg_pattern(input logic [3:0] nib);
        string      lit;
        logic [7:0] bits;
        case (nib)
            4'h0: lit = "abcdef";
            4'h1: lit = "bc";
            4'h2: lit = "abdeg";
            4'h3: lit = "abcdg";
            4'h4: lit = "bcfg";
            4'h5: lit = "acdfg";
            4'h6: lit = "acdefg";
            4'h7: lit = "abc";
            4'h8: lit = "abcdefg";
            4'h9: lit = "abcdfg";
            4'ha: lit = "abcefg";
            4'hb: lit = "cdefg";
            4'hc: lit = "adef";
            4'hd: lit = "bcdeg";
            4'he: lit = "adefg";
            default: lit = "aefg";
        endcase
        bits = 8'h00;
        for (int i = 0; i < lit.len(); i++)
            bits = bits | (8'h80 >> (lit[i] - "a"));
        return bits;
    endfunction

    task automatic stop_with_failure();
        $display("Test failures found");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    // ----------------------------------------
    // Compare tasks
    // ----------------------------------------
    task automatic check_led(input led_t exp, input led_t act);
        if (act !== exp)
        begin
            $display("FAIL time=%0t signal=led expected=%h actual=%h", $time, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_number_segments(input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp)
        begin
            $display("FAIL time=%0t signal=abcdefgh expected=%b actual=%b", $time, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_digit(input logic [`LAB_W_DIGIT - 1:0] exp,
                               input logic [`LAB_W_DIGIT - 1:0] act);
        if (act !== exp)
        begin
            $display("FAIL time=%0t signal=digit expected=%b actual=%b", $time, exp, act);
            stop_with_failure();
        end
    endtask

    // One clock edge of the model
    // Old values feed every stage
    task automatic advance_model();
        logic [`LAB_W_IN - 1:0]    word;
        counters_t                 cnt_n;
        logic [3:0]                nib;
        word = use_sw ? `LAB_W_IN'(sw) : `LAB_W_IN'(key);
        if (rst_from_key0)
        begin
            m_cnt = '0;
            m_run = 0;
            m_meta = '0;
            m_sync = '0;
            m_led = '0;
            m_num = '0;
            m_seg = seg_pattern(4'h0);
            m_digit = `LAB_W_DIGIT'(1);
            m_scan = 0;
            m_idx = 0;
        end
        else
        begin
            // Registered result stage
            m_led = pick_value(m_sync, m_cnt);
            nib = 4'(m_num >> (4 * m_idx));
            m_seg = seg_pattern(nib);
            m_digit = `LAB_W_DIGIT'(1) << m_idx;
            m_num = (|m_sync) ? number_t'(pick_value(m_sync, m_cnt))
                              : number_t'(m_cnt.free_cnt);
            // Digit index steps once per scan period
            if (m_scan == `LAB_SCAN_PERIOD - 1)
            begin
                m_scan = 0;
                m_idx = (m_idx + 1) % `LAB_W_DIGIT;
            end
            else
                m_scan = m_scan + 1;
            // Two-stage synchronizer
            m_sync = m_meta;
            m_meta = word;
            // Strobed counts land the cycle after each period boundary
            cnt_n = m_cnt;
            cnt_n.free_cnt = m_cnt.free_cnt + 32'd1;
            if (m_run > 0 && m_run % `LAB_SLOW_PERIOD == 0)
                cnt_n.slow_cnt = m_cnt.slow_cnt + 8'd1;
            if (m_cnt.free_cnt[`LAB_TICK_BITS - 1:0] == '0)
                cnt_n.tick_cnt = m_cnt.tick_cnt + 8'd1;
            if (m_run > 0 && m_run % `LAB_STROBE_PERIOD == 0)
                cnt_n.strobe_cnt = m_cnt.strobe_cnt + 8'd1;
            m_cnt = cnt_n;
            m_run = m_run + 1;
        end
    endtask

    // Sample 1 ns after the edge where outputs are settled
    task automatic step();
        @(posedge clk);
        advance_model();
        #1;
        check_led(m_led, led);
        check_number_segments(m_seg, abcdefgh);
        check_digit(m_digit, digit);
    endtask

    task automatic hold_and_count(input int cycles, output int changes);
        led_t prev;
        prev = led;
        changes = 0;
        repeat (cycles)
        begin
            step();
            if (led != prev)
                changes = changes + 1;
            prev = led;
        end
    endtask

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    initial
    begin
        logic [31:0] r;
        int          hold;
        int          changes;
        rng_state = 32'h69891c1b;
        rst_from_key0 = 1'b1;
        key = '0;
        sw = '0;
        // Reset state is checked on every edge
        repeat (n_reset_cycles) step();
        rst_from_key0 = 1'b0;
        // Random select codes with idle spells
        for (int s = 0; s < n_segments; s++)
        begin
            r = next_random();
            hold = 1 + int'(r[15:8]) % max_hold;
            if (r[2:0] == 3'd0)
                sw = '0;
            else
                sw = `LAB_W_SW'(r[31:24]);
            key = `LAB_W_KEY'(r[23:20]);
            repeat (hold) step();
        end
        // Tick cadence
        sw = `LAB_W_SW'(8'b0000_1010);
        hold_and_count(tick_hold, changes);
        if (changes < 4)
        begin
            $display("The LEDs did not follow the tick counter while it was selected");
            stop_with_failure();
        end
        // Strobe cadence
        sw = `LAB_W_SW'(8'b0000_1100);
        hold_and_count(strobe_hold, changes);
        if (changes < 4)
        begin
            $display("The LEDs did not follow the strobe counter while it was selected");
            stop_with_failure();
        end
        else
        begin
            $display("All tests passed!");
            $finish;
        end
    end

    // Watchdog
    initial
    begin
        #(max_cycles * 10 + 1000);
        $display("Watchdog expired before the tests finished");
        stop_with_failure();
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+common
common/lab_pkg.sv
source/input_decode.sv
counters/strobe_gen.sv
counters/counter_bank.sv
source/result_select.sv
display/seven_segment_display.sv
source/lab_top.sv
verification/tb_lab_top.sv

// File: run_sim.sh
#!/bin/sh
# Builds and runs the testbench, exit status follows the simulation
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -f tb.f --top-module tb_lab_top -Mdir obj_dir \
    && ./obj_dir/Vtb_lab_top \
    || { echo "Simulation failed"; exit 1; }
